// File: filelist.f
design/axi_ls_pkg.sv
design/axi_ls_ctrl.sv
design/axi_ls_addr_hold.sv
design/axi_ls_rdata_hold.sv
design/axi_mem_slave.sv
design/axi_ls_top.sv
dv/axi_ls_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := axi_ls_tb
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
SIM_BIN    := $(OBJ_DIR)/$(TOP)_sim
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)_sim
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/axi_ls_tb.sv
`timescale 1ns/100ps

module axi_ls_tb;
    import axi_ls_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int N_RAND       = 32;
    localparam int ENTRY_CYCLES = 40;   // worst transfer with 3 waits per channel is far below
    localparam logic [1:0] K_WR   = 2'd0;
    localparam logic [1:0] K_RD   = 2'd1;
    localparam logic [1:0] K_HOLD = 2'd2;  // read held, then address switched

    logic  clock;
    logic  reset;
    logic  rd_valid_i;
    logic  wr_valid_i;
    addr_t addr_i;
    data_t wdata_i;
    strb_t wmask_i;
    logic  rd_ready_o;
    data_t rdata_o;
    logic  wr_ok_o;
    logic  err_o;

    // stimulus table, one row per entry
    logic [1:0] kind_q [$];
    addr_t      addr_q [$];
    data_t      data_q [$];  // write data, or second address of a held read
    strb_t      mask_q [$];
    string      name_q [$];

    data_t       ref_mem [MEM_WORDS];
    logic [31:0] rng;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    axi_ls_top axi_ls_top_inst (
        .clock      (clock),
        .reset      (reset),
        .rd_valid_i (rd_valid_i),
        .wr_valid_i (wr_valid_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .wmask_i    (wmask_i),
        .rd_ready_o (rd_ready_o),
        .rdata_o    (rdata_o),
        .wr_ok_o    (wr_ok_o),
        .err_o      (err_o)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("timeout: no result from the bridge after %0d cycles", cycle_cnt));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_err(input string name, input bit exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s err: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s status: expected %b, actual %b", name, exp, act));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic bit in_memory(input addr_t a);
        return a < addr_t'(MEM_WORDS * 8);
    endfunction

    // word index is address bits 10:3
    function automatic data_t ref_read(input addr_t a);
        if (in_memory(a)) begin
            return ref_mem[a[10:3]];
        end
        return '0;
    endfunction

    task automatic ref_write(input addr_t a, input data_t d, input strb_t m);
        if (in_memory(a)) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (m[b]) ref_mem[a[10:3]][8*b +: 8] = d[8*b +: 8];
            end
        end
    endtask

    task automatic add_entry(input logic [1:0] k, input addr_t a, input data_t d,
                             input strb_t m, input string name);
        kind_q.push_back(k);
        addr_q.push_back(a);
        data_q.push_back(d);
        mask_q.push_back(m);
        name_q.push_back(name);
    endtask

    // sample on the falling edge, status lands there
    task automatic wait_done(input bit is_read);
        do begin
            @(negedge clock);
        end while ((is_read ? rd_ready_o : wr_ok_o) !== 1'b1);
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic run_entry(input int i);
        string nm;
        addr_t a;
        addr_t a2;
        nm = name_q[i];
        a  = addr_q[i];
        a2 = data_q[i];
        addr_i = a;
        if (kind_q[i] == K_WR) begin
            wdata_i    = data_q[i];
            wmask_i    = mask_q[i];
            wr_valid_i = 1'b1;
            wait_done(1'b0);
            ref_write(a, data_q[i], mask_q[i]);
            check_err(nm, !in_memory(a), err_o);
        end else begin
            rd_valid_i = 1'b1;
            wait_done(1'b1);
            check_data(nm, ref_read(a), rdata_o);
            check_err(nm, !in_memory(a), err_o);
            if (kind_q[i] == K_HOLD) begin
                repeat (4) begin
                    @(negedge clock);
                    check_flag({nm, " hold"}, 1'b1, rd_ready_o);
                    check_data({nm, " hold"}, ref_read(a), rdata_o);
                end
                @(posedge clock);
                #1;
                addr_i = a2;  // new address, request stays up
                @(negedge clock);
                check_flag({nm, " switch"}, 1'b0, rd_ready_o);
                wait_done(1'b1);
                check_data({nm, " new address"}, ref_read(a2), rdata_o);
                check_err({nm, " new address"}, !in_memory(a2), err_o);
            end
        end
        @(posedge clock);
        #1;
        rd_valid_i = 1'b0;
        wr_valid_i = 1'b0;
        @(negedge clock);
        check_flag({nm, " drop rd"}, 1'b0, rd_ready_o);
        check_flag({nm, " drop wr"}, 1'b0, wr_ok_o);
        @(posedge clock);
        #1;
    endtask

    initial begin
        addr_t       a;
        data_t       d;
        strb_t       m;
        logic [1:0]  k;
        clock      = 1'b0;
        reset      = 1'b0;
        rd_valid_i = 1'b0;
        wr_valid_i = 1'b0;
        addr_i     = '0;
        wdata_i    = '0;
        wmask_i    = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end

        add_entry(K_WR, 64'h40, 64'h0123_4567_89ab_cdef, 8'hff, "full write");
        add_entry(K_RD, 64'h40, '0, '0, "full read");
        add_entry(K_WR, 64'h40, 64'hffee_ddcc_bbaa_9988, 8'h5a, "partial write");
        add_entry(K_RD, 64'h40, '0, '0, "partial read");
        add_entry(K_WR, 64'h7f8, 64'h5555_aaaa_3c3c_c3c3, 8'hff, "top word write");
        add_entry(K_HOLD, 64'h40, 64'h7f8, '0, "held read");
        add_entry(K_WR, 64'h800, 64'hdead_beef_dead_beef, 8'hff, "range write");
        add_entry(K_RD, 64'h800, '0, '0, "range read");
        add_entry(K_RD, 64'h8000_0000_0000_0040, '0, '0, "far read");  // aliases 0x40 in bits 10:3

        rng = 32'hee7e;
        for (int n = 0; n < N_RAND; n++) begin
            rng      = xorshift32(rng);
            a        = addr_t'({rng[3:0], 4'h0, 3'b000});  // 16 words spread over memory
            m        = rng[23:16];
            k        = rng[9] ? K_WR : K_RD;
            rng      = xorshift32(rng);
            d[63:32] = rng;
            rng      = xorshift32(rng);
            d[31:0]  = rng;
            add_entry(k, a, d, m, $sformatf("random %0d", n));
        end
        cycle_limit = (kind_q.size() + 2) * ENTRY_CYCLES + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b1;
        @(negedge clock);
        check_flag("reset rd_ready", 1'b0, rd_ready_o);
        check_flag("reset wr_ok", 1'b0, wr_ok_o);
        check_err("reset", 1'b0, err_o);
        check_data("reset rdata", '0, rdata_o);
        @(posedge clock);
        #1;

        for (int i = 0; i < kind_q.size(); i++) begin
            run_entry(i);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: design/axi_ls_top.sv
`timescale 1ns/100ps

module axi_ls_top (
    input  logic               clock,
    input  logic               reset,
    input  logic               rd_valid_i,
    input  logic               wr_valid_i,
    input  axi_ls_pkg::addr_t  addr_i,
    input  axi_ls_pkg::data_t  wdata_i,
    input  axi_ls_pkg::strb_t  wmask_i,
    output logic               rd_ready_o,
    output axi_ls_pkg::data_t  rdata_o,
    output logic               wr_ok_o,
    output logic               err_o
);
    import axi_ls_pkg::*;

    logic  aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic  ar_valid, ar_ready, r_valid, r_ready;
    resp_t b_resp, r_resp;
    data_t r_data;
    logic  addr_load, addr_same, rdata_show, r_err;

    // fixed attributes, single beat, one id
    logic [ID_W-1:0] aw_id, ar_id;
    logic [7:0]      aw_len, ar_len;
    logic [2:0]      aw_size, ar_size, aw_prot, ar_prot;
    logic [1:0]      aw_burst, ar_burst;
    logic [3:0]      aw_cache, ar_cache;
    logic            w_last;

    assign aw_id    = AXI_ID;
    assign ar_id    = AXI_ID;
    assign aw_len   = AXI_LEN;
    assign ar_len   = AXI_LEN;
    assign aw_size  = AXI_SIZE;
    assign ar_size  = AXI_SIZE;
    assign aw_burst = AXI_BURST_INCR;
    assign ar_burst = AXI_BURST_INCR;
    assign aw_prot  = AXI_PROT_DATA;
    assign ar_prot  = AXI_PROT_DATA;
    assign aw_cache = AXI_CACHE_NORMAL;
    assign ar_cache = AXI_CACHE_NORMAL;
    assign w_last   = w_valid;  // every beat is the last

    axi_ls_ctrl axi_ls_ctrl_inst (
        .clock        (clock),
        .reset        (reset),
        .rd_valid_i   (rd_valid_i),
        .wr_valid_i   (wr_valid_i),
        .addr_same_i  (addr_same),
        .aw_ready_i   (aw_ready),
        .w_ready_i    (w_ready),
        .b_valid_i    (b_valid),
        .b_resp_i     (b_resp),
        .ar_ready_i   (ar_ready),
        .r_valid_i    (r_valid),
        .r_err_i      (r_err),
        .aw_valid_o   (aw_valid),
        .w_valid_o    (w_valid),
        .b_ready_o    (b_ready),
        .ar_valid_o   (ar_valid),
        .r_ready_o    (r_ready),
        .addr_load_o  (addr_load),
        .rdata_show_o (rdata_show),
        .rd_ready_o   (rd_ready_o),
        .wr_ok_o      (wr_ok_o),
        .err_o        (err_o)
    );

    axi_ls_addr_hold axi_ls_addr_hold_inst (
        .clock       (clock),
        .reset       (reset),
        .load_i      (addr_load),
        .addr_i      (addr_i),
        .addr_same_o (addr_same)
    );

    axi_ls_rdata_hold axi_ls_rdata_hold_inst (
        .clock     (clock),
        .reset     (reset),
        .capture_i (r_valid & r_ready),
        .show_i    (rdata_show),
        .r_data_i  (r_data),
        .r_resp_i  (r_resp),
        .rdata_o   (rdata_o),
        .r_err_o   (r_err)
    );

    // address and write data straight from the core
    axi_mem_slave axi_mem_slave_inst (
        .clock      (clock),
        .reset      (reset),
        .aw_valid_i (aw_valid),
        .aw_addr_i  (addr_i),
        .w_valid_i  (w_valid),
        .w_data_i   (wdata_i),
        .w_strb_i   (wmask_i),
        .b_ready_i  (b_ready),
        .ar_valid_i (ar_valid),
        .ar_addr_i  (addr_i),
        .r_ready_i  (r_ready),
        .aw_ready_o (aw_ready),
        .w_ready_o  (w_ready),
        .b_valid_o  (b_valid),
        .b_resp_o   (b_resp),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_data_o   (r_data),
        .r_resp_o   (r_resp)
    );

endmodule

// File: design/axi_mem_slave.sv
`timescale 1ns/100ps

module axi_mem_slave (
    input  logic               clock,
    input  logic               reset,
    input  logic               aw_valid_i,
    input  axi_ls_pkg::addr_t  aw_addr_i,
    input  logic               w_valid_i,
    input  axi_ls_pkg::data_t  w_data_i,
    input  axi_ls_pkg::strb_t  w_strb_i,
    input  logic               b_ready_i,
    input  logic               ar_valid_i,
    input  axi_ls_pkg::addr_t  ar_addr_i,
    input  logic               r_ready_i,
    output logic               aw_ready_o,
    output logic               w_ready_o,
    output logic               b_valid_o,
    output axi_ls_pkg::resp_t  b_resp_o,
    output logic               ar_ready_o,
    output logic               r_valid_o,
    output axi_ls_pkg::data_t  r_data_o,
    output axi_ls_pkg::resp_t  r_resp_o
);
    import axi_ls_pkg::*;

    data_t             mem [MEM_WORDS];
    logic [LFSR_W-1:0] lfsr_q;
    logic [1:0]        wait_q [3];   // 0 aw, 1 w, 2 ar
    logic [2:0]        elig;         // channel may accept now
    logic [2:0]        hs;
    logic              aw_got_q;     // write address taken, waiting for data
    addr_t             aw_addr_q;
    logic              aw_in_range, ar_in_range;

    assign aw_in_range = (aw_addr_q < addr_t'(MEM_WORDS * 8));
    assign ar_in_range = (ar_addr_i < addr_t'(MEM_WORDS * 8));

    assign elig[0] = aw_valid_i && !aw_got_q && !b_valid_o;
    assign elig[1] = w_valid_i && aw_got_q;
    assign elig[2] = ar_valid_i && !r_valid_o;

    assign aw_ready_o = elig[0] && (wait_q[0] == 2'd0);
    assign w_ready_o  = elig[1] && (wait_q[1] == 2'd0);
    assign ar_ready_o = elig[2] && (wait_q[2] == 2'd0);
    assign hs         = {ar_ready_o, w_ready_o, aw_ready_o};

    // free-running, x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            lfsr_q <= LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 3; i++) wait_q[i] <= 2'd0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (hs[i]) begin
                    wait_q[i] <= lfsr_q[2*i +: 2];  // 0..3 waits for the next one
                end else if (elig[i] && wait_q[i] != 2'd0) begin
                    wait_q[i] <= wait_q[i] - 2'd1;
                end
            end
        end
    end

    // write path, memory cleared on reset
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < MEM_WORDS; i++) mem[i] <= '0;
            aw_got_q  <= 1'b0;
            aw_addr_q <= '0;
            b_valid_o <= 1'b0;
            b_resp_o  <= RESP_OKAY;
        end else begin
            if (hs[0]) begin
                aw_got_q  <= 1'b1;
                aw_addr_q <= aw_addr_i;
            end
            if (hs[1]) begin
                aw_got_q  <= 1'b0;
                b_valid_o <= 1'b1;
                b_resp_o  <= aw_in_range ? RESP_OKAY : RESP_SLVERR;
                if (aw_in_range) begin
                    for (int b = 0; b < STRB_W; b++) begin
                        if (w_strb_i[b]) mem[aw_addr_q[3 +: MEM_IDX_W]][8*b +: 8] <= w_data_i[8*b +: 8];
                    end
                end
            end else if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
            end
        end
    end

    // read path
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            r_valid_o <= 1'b0;
            r_data_o  <= '0;
            r_resp_o  <= RESP_OKAY;
        end else if (hs[2]) begin
            r_valid_o <= 1'b1;
            r_data_o  <= ar_in_range ? mem[ar_addr_i[3 +: MEM_IDX_W]] : '0;
            r_resp_o  <= ar_in_range ? RESP_OKAY : RESP_SLVERR;
        end else if (r_valid_o && r_ready_i) begin
            r_valid_o <= 1'b0;
        end
    end

endmodule

// File: design/axi_ls_rdata_hold.sv
`timescale 1ns/100ps

module axi_ls_rdata_hold (
    input  logic               clock,
    input  logic               reset,
    input  logic               capture_i,
    input  logic               show_i,
    input  axi_ls_pkg::data_t  r_data_i,
    input  axi_ls_pkg::resp_t  r_resp_i,
    output axi_ls_pkg::data_t  rdata_o,
    output logic               r_err_o
);
    import axi_ls_pkg::*;

    data_t data_q;
    logic  err_q;

    always_ff @(posedge clock) begin
        if (capture_i) data_q <= r_data_i;  // r handshake
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            err_q <= 1'b0;
        end else if (capture_i) begin
            err_q <= (r_resp_i != RESP_OKAY);
        end
    end

    // zero whenever the result is not shown
    assign rdata_o = show_i ? data_q : '0;
    assign r_err_o = err_q;

endmodule

// File: design/axi_ls_addr_hold.sv
`timescale 1ns/100ps

module axi_ls_addr_hold (
    input  logic               clock,
    input  logic               reset,
    input  logic               load_i,
    input  axi_ls_pkg::addr_t  addr_i,
    output logic               addr_same_o
);
    import axi_ls_pkg::*;

    addr_t addr_q;  // address of the transfer in flight

    // tracks the core address while aw or ar is issued
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            addr_q <= '0;
        end else if (load_i) begin
            addr_q <= addr_i;
        end
    end

    // repeated request vs new one
    assign addr_same_o = (addr_q == addr_i);

endmodule

// File: design/axi_ls_ctrl.sv
`timescale 1ns/100ps

module axi_ls_ctrl (
    input  logic               clock,
    input  logic               reset,
    input  logic               rd_valid_i,
    input  logic               wr_valid_i,
    input  logic               addr_same_i,
    input  logic               aw_ready_i,
    input  logic               w_ready_i,
    input  logic               b_valid_i,
    input  axi_ls_pkg::resp_t  b_resp_i,
    input  logic               ar_ready_i,
    input  logic               r_valid_i,
    input  logic               r_err_i,
    output logic               aw_valid_o,
    output logic               w_valid_o,
    output logic               b_ready_o,
    output logic               ar_valid_o,
    output logic               r_ready_o,
    output logic               addr_load_o,
    output logic               rdata_show_o,
    output logic               rd_ready_o,
    output logic               wr_ok_o,
    output logic               err_o
);
    import axi_ls_pkg::*;

    w_state_t w_state_q, w_state_d;
    r_state_t r_state_q, r_state_d;
    logic     b_seen_q;   // b response taken in b_done
    resp_t    b_resp_q;
    logic     aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic     wr_show, rd_show;

    assign aw_hs = aw_valid_o & aw_ready_i;
    assign w_hs  = w_valid_o & w_ready_i;
    assign b_hs  = b_valid_i & b_ready_o;
    assign ar_hs = ar_valid_o & ar_ready_i;
    assign r_hs  = r_valid_i & r_ready_o;

    always_comb begin
        w_state_d = w_state_q;
        case (w_state_q)
            W_IDLE:    if (wr_valid_i) w_state_d = W_AW_WAIT;
            W_AW_WAIT: if (aw_hs) w_state_d = W_W_WAIT;
            W_W_WAIT:  if (w_hs) w_state_d = W_B_DONE;
            W_B_DONE: begin
                // leave only once the response is in
                if (b_seen_q) begin
                    if (!wr_valid_i) begin
                        w_state_d = W_IDLE;
                    end else if (!addr_same_i) begin
                        w_state_d = W_AW_WAIT;  // new address, no idle pass
                    end
                end
            end
            default:   w_state_d = W_IDLE;
        endcase
    end

    always_comb begin
        r_state_d = r_state_q;
        case (r_state_q)
            R_IDLE:    if (rd_valid_i) r_state_d = R_AR_WAIT;
            R_AR_WAIT: if (ar_hs) r_state_d = R_R_WAIT;
            R_R_WAIT:  if (r_hs) r_state_d = R_R_DONE;
            R_R_DONE: begin
                if (!rd_valid_i) begin
                    r_state_d = R_IDLE;
                end else if (!addr_same_i) begin
                    r_state_d = R_AR_WAIT;
                end
            end
            default:   r_state_d = R_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state_q <= W_IDLE;
            r_state_q <= R_IDLE;
            b_seen_q  <= 1'b0;
            b_resp_q  <= RESP_OKAY;
        end else begin
            w_state_q <= w_state_d;
            r_state_q <= r_state_d;
            if (b_hs) begin
                b_seen_q <= 1'b1;
                b_resp_q <= b_resp_i;
            end else if (w_state_d != W_B_DONE) begin
                b_seen_q <= 1'b0;
            end
        end
    end

    assign aw_valid_o  = (w_state_q == W_AW_WAIT);
    assign w_valid_o   = (w_state_q == W_W_WAIT);
    assign b_ready_o   = (w_state_q == W_B_DONE) && !b_seen_q;
    assign ar_valid_o  = (r_state_q == R_AR_WAIT);
    assign r_ready_o   = (r_state_q == R_R_WAIT);
    assign addr_load_o = aw_valid_o | ar_valid_o;

    // status only while request and address still match
    assign wr_show = (w_state_q == W_B_DONE) && b_seen_q && wr_valid_i && addr_same_i;
    assign rd_show = (r_state_q == R_R_DONE) && rd_valid_i && addr_same_i;

    assign rdata_show_o = rd_show;
    assign rd_ready_o   = rd_show;
    assign wr_ok_o      = wr_show;
    assign err_o        = (wr_show && (b_resp_q == RESP_SLVERR)) || (rd_show && r_err_i);

endmodule

// File: design/axi_ls_pkg.sv
package axi_ls_pkg;

    // data path widths
    localparam int XLEN      = 64;
    localparam int STRB_W    = XLEN / 8;
    localparam int ID_W      = 4;
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);  // word index, addr bits 10:3

    // slave wait-state generator
    localparam int LFSR_W = 8;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 8'ha5;

    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [XLEN-1:0]   data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // single-beat transfer attributes
    localparam logic [ID_W-1:0] AXI_ID           = 4'h1;
    localparam logic [7:0]      AXI_LEN          = 8'h00;              // one beat
    localparam logic [2:0]      AXI_SIZE         = 3'($clog2(STRB_W)); // full bus width
    localparam logic [1:0]      AXI_BURST_INCR   = 2'b01;
    localparam logic [2:0]      AXI_PROT_DATA    = 3'b000;  // unprivileged, secure, data
    localparam logic [3:0]      AXI_CACHE_NORMAL = 4'b0010; // normal, non-cacheable

    // write machine: address, data, then response and hold
    typedef enum logic [1:0] {
        W_IDLE    = 2'b00,
        W_AW_WAIT = 2'b01,
        W_W_WAIT  = 2'b11,
        W_B_DONE  = 2'b10
    } w_state_t;

    // read machine: address, then data and hold
    typedef enum logic [1:0] {
        R_IDLE    = 2'b00,
        R_AR_WAIT = 2'b01,
        R_R_WAIT  = 2'b11,
        R_R_DONE  = 2'b10
    } r_state_t;

endpackage
